// File: src.f
+incdir+verilog
verilog/dm_reg_pkg.sv
verilog/dm_hart_pkg.sv
verilog/dm_resp_fifo.sv
verilog/dm_ctrl_regs.sv
verilog/dm_hart_slice.sv
verilog/dm_status_merge.sv
verilog/dm_top.sv
verif/dm_tb_checker.sv
verif/dm_tb.sv

// File: Makefile
RTL = verilog/dm_reg_pkg.sv verilog/dm_hart_pkg.sv verilog/dm_resp_fifo.sv \
      verilog/dm_ctrl_regs.sv verilog/dm_hart_slice.sv verilog/dm_status_merge.sv \
      verilog/dm_top.sv

.PHONY: all run lint clean

all: run

obj_dir/Vdm_tb: src.f $(RTL) verif/dm_tb.sv verif/dm_tb_checker.sv
	verilator --binary --timing --assert -f src.f --top-module dm_tb

run: obj_dir/Vdm_tb
	./obj_dir/Vdm_tb

lint:
	verilator --lint-only +incdir+verilog $(RTL) --top-module dm_top

clean:
	rm -rf obj_dir

// File: verif/dm_tb.sv
/* debug module testbench
   table-driven DMI requests with hart-side checks and a back-pressure run */

`include "dm_cfg.svh"

module dm_tb;
  import dm_reg_pkg::*;
  import dm_hart_pkg::*;

  logic clk_i, rst_ni, req_valid, req_ready, resp_valid, resp_ready, ndmreset, dmactive, clr_ack;
  dtm_op_t req_op;
  dmi_addr_t req_addr;
  dmi_data_t req_data, resp_data, got;
  hart_vec_t halted, unavail, ack, haltreq, resumereq, hr, hv, uv;
  logic [31:0] lfsr_q;
  int unsigned pulses;
  logic exp_active, exp_ndmreset;

  // stimulus table with one entry per step
  string t_name[$];
  dtm_op_t t_op[$];
  dmi_addr_t t_addr[$];
  dmi_data_t t_wdata[$], t_resp[$];
  hart_vec_t t_halted[$], t_unavail[$], t_ack[$], t_haltreq[$], t_resumereq[$];

  dm_top dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .dmi_req_valid_i (req_valid), .dmi_req_ready_o (req_ready), .dmi_req_op_i (req_op),
    .dmi_req_addr_i (req_addr), .dmi_req_data_i (req_data),
    .dmi_resp_valid_o (resp_valid), .dmi_resp_ready_i (resp_ready),
    .dmi_resp_data_o (resp_data), .halted_i (halted), .unavailable_i (unavail),
    .resumeack_i (ack), .haltreq_o (haltreq), .resumereq_o (resumereq),
    .ndmreset_o (ndmreset), .dmactive_o (dmactive), .clear_resumeack_o (clr_ack)
  );

  bind dm_top dm_tb_checker u_checker (
    .clk_i (clk_i), .rst_ni (rst_ni), .haltreq_o (haltreq_o), .resumereq_o (resumereq_o),
    .dmi_req_ready_o (dmi_req_ready_o), .dmi_resp_valid_o (dmi_resp_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (clr_ack) begin
      pulses <= pulses + 1;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic hart_vec_t lfsr_bits();
    hart_vec_t v;
    for (int i = 0; i < `NR_HARTS; i++) begin
      v[i] = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // dmstatus as the register map defines it for one selected hart
  function automatic dmi_data_t status_of(int sel, hart_vec_t h, hart_vec_t u, hart_vec_t a,
                                          hart_vec_t r);
    dmi_data_t s;
    s = 32'h0000_0082;
    if (sel >= `NR_HARTS) return s | 32'h0000_c000;
    if (h[sel] && !u[sel]) s = s | 32'h0000_0300;
    if (!h[sel] && !u[sel]) s = s | 32'h0000_0c00;
    if (u[sel]) s = s | 32'h0000_3000;
    if (a[sel]) s = s | 32'h0003_0000;
    if (r[sel]) s = s | 32'h000c_0000;
    return s;
  endfunction

  task automatic add(string n, dtm_op_t op, dmi_addr_t ad, dmi_data_t wd, hart_vec_t h,
                     hart_vec_t u, hart_vec_t a, dmi_data_t rsp, hart_vec_t hq, hart_vec_t rq);
    t_name.push_back(n);
    t_op.push_back(op);
    t_addr.push_back(ad);
    t_wdata.push_back(wd);
    t_halted.push_back(h);
    t_unavail.push_back(u);
    t_ack.push_back(a);
    t_resp.push_back(rsp);
    t_haltreq.push_back(hq);
    t_resumereq.push_back(rq);
  endtask

  task automatic check(string n, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", n, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // called and returns on a falling edge
  task automatic send_req(dtm_op_t op, dmi_addr_t ad, dmi_data_t wd);
    int cnt;
    cnt = 0;
    req_valid = 1'b1;
    req_op = op;
    req_addr = ad;
    req_data = wd;
    while (!req_ready) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > 100) begin
        $display("Simulation failed");
        $fatal(1, "request was never accepted");
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    req_valid = 1'b0;
  endtask

  task automatic get_resp(output dmi_data_t d);
    int cnt;
    cnt = 0;
    while (!resp_valid) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > 100) begin
        $display("Simulation failed");
        $fatal(1, "no response arrived");
      end
    end
    d = resp_data;
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  initial begin
    rst_ni = 1'b0;
    req_valid = 1'b0;
    req_op = DTM_NOP;
    req_addr = '0;
    req_data = '0;
    resp_ready = 1'b1;
    halted = '0;
    unavail = '0;
    ack = '0;
    pulses = 0;
    exp_active = 1'b0;
    exp_ndmreset = 1'b0;
    lfsr_q = 32'h4cce_a9ff;
    hr = '1;
    // --------------------
    // gating and selection
    add("gate_write", DTM_WRITE, 7'h10, 32'h8000_0000, 0, 0, 0, 0, 0, 0);
    add("gate_read", DTM_READ, 7'h10, 0, 0, 0, 0, 0, 0, 0);
    add("active_write", DTM_WRITE, 7'h10, 32'h8000_0001, 0, 0, 0, 0, 4'b0001, 0);
    add("active_read", DTM_READ, 7'h10, 0, 0, 0, 0, 32'h8000_0001, 4'b0001, 0);
    add("sel2_write", DTM_WRITE, 7'h10, 32'h8002_0001, 0, 0, 0, 0, 4'b0100, 0);
    add("sel5_write", DTM_WRITE, 7'h10, 32'h8005_0001, 0, 0, 0, 0, 0, 0);
    add("sel5_status", DTM_READ, 7'h11, 0, 0, 0, 0, status_of(5, 0, 0, 0, hr), 0, 0);
    add("unmapped", DTM_READ, 7'h05, 0, 0, 0, 0, 0, 0, 0);
    // --------------------
    // havereset and selected status
    add("sel0_write", DTM_WRITE, 7'h10, 32'h0000_0001, 0, 0, 0, 0, 0, 0);
    add("sel0_status", DTM_READ, 7'h11, 0, 4'b0001, 0, 0, status_of(0, 4'b0001, 0, 0, hr), 0, 0);
    add("ack_write", DTM_WRITE, 7'h10, 32'h1000_0001, 0, 0, 0, 0, 0, 0);
    hr[0] = 1'b0;
    add("acked_status", DTM_READ, 7'h11, 0, 0, 0, 0, status_of(0, 0, 0, 0, hr), 0, 0);
    add("sel1_write", DTM_WRITE, 7'h10, 32'h0001_0001, 0, 0, 0, 0, 0, 0);
    add("sel1_unavail", DTM_READ, 7'h11, 0, 4'b0010, 4'b0010, 0,
        status_of(1, 4'b0010, 4'b0010, 0, hr), 0, 0);
    for (int i = 0; i < 3; i++) begin
      hv = lfsr_bits();
      uv = lfsr_bits();
      add("rand_status", DTM_READ, 7'h11, 0, hv, uv, 0, status_of(1, hv, uv, 0, hr), 0, 0);
      add("haltsum0", DTM_READ, 7'h40, 0, hv, 0, 0, 32'(hv), 0, 0);
    end
    add("ndmreset_set", DTM_WRITE, 7'h10, 32'h0000_0003, 0, 0, 0, 0, 0, 0);
    add("ndmreset_clr", DTM_WRITE, 7'h10, 32'h0000_0001, 0, 0, 0, 0, 0, 0);
    hr = '1;
    add("reset_status", DTM_READ, 7'h11, 0, 0, 0, 0, status_of(0, 0, 0, 0, hr), 0, 0);
    // --------------------
    // resume handshake on hart 1
    add("resume_write", DTM_WRITE, 7'h10, 32'h4001_0001, 0, 0, 0, 0, 0, 4'b0010);
    add("resume_ack", DTM_NOP, 7'h00, 0, 0, 0, 4'b0010, 0, 0, 0);
    add("resume_read", DTM_READ, 7'h10, 0, 0, 0, 4'b0010, 32'h0001_0001, 0, 0);

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    foreach (t_name[i]) begin
      halted = t_halted[i];
      unavail = t_unavail[i];
      ack = t_ack[i];
      send_req(t_op[i], t_addr[i], t_wdata[i]);
      get_resp(got);
      // a dmcontrol write sets dmactive, and ndmreset only while active
      if (t_op[i] == DTM_WRITE && t_addr[i] == 7'h10) begin
        exp_active = t_wdata[i][0];
        exp_ndmreset = t_wdata[i][1] & t_wdata[i][0];
      end
      check(t_name[i], t_resp[i], got);
      check({t_name[i], "_haltreq"}, 32'(t_haltreq[i]), 32'(haltreq));
      check({t_name[i], "_resumereq"}, 32'(t_resumereq[i]), 32'(resumereq));
      check({t_name[i], "_dmactive"}, 32'(exp_active), 32'(dmactive));
      check({t_name[i], "_ndmreset"}, 32'(exp_ndmreset), 32'(ndmreset));
    end
    check("resumeack_pulses", 1, pulses);
    ack = '0;

    // two reads fill the queue and the third waits
    resp_ready = 1'b0;
    send_req(DTM_READ, 7'h10, 0);
    send_req(DTM_READ, 7'h40, 0);
    check("ready_low", 0, 32'(req_ready));
    req_valid = 1'b1;
    req_op = DTM_READ;
    req_addr = 7'h11;
    resp_ready = 1'b1;
    get_resp(got);
    check("bp_first", 32'h0001_0001, got);
    get_resp(got);
    req_valid = 1'b0;
    check("bp_second", 0, got);
    get_resp(got);
    check("bp_third", status_of(1, 0, 0, 0, hr), got);

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verif/dm_tb_checker.sv
/* debug module checker
   hart request encoding and DMI handshake properties */

module dm_tb_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input dm_hart_pkg::hart_vec_t haltreq_o,
  input dm_hart_pkg::hart_vec_t resumereq_o,
  input logic                   dmi_req_ready_o,
  input logic                   dmi_resp_valid_o
);

  // only the selected hart gets a request
  haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o))
    else $error("haltreq_o has more than one bit set");

  resumereq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(resumereq_o))
    else $error("resumereq_o has more than one bit set");

  // queue starts empty
  resp_idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !dmi_resp_valid_o)
    else $error("response valid right after reset");

  // a full queue always has a word to offer
  full_has_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dmi_req_ready_o |-> dmi_resp_valid_o)
    else $error("request ready low with no response pending");

endmodule

// File: verilog/dm_top.sv
/* debug module top
   register block, hart slices, status merger and response queue */

`include "dm_cfg.svh"

module dm_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // DMI request
  input  logic                   dmi_req_valid_i,
  output logic                   dmi_req_ready_o,
  input  dm_reg_pkg::dtm_op_t    dmi_req_op_i,
  input  dm_reg_pkg::dmi_addr_t  dmi_req_addr_i,
  input  dm_reg_pkg::dmi_data_t  dmi_req_data_i,
  // DMI response
  output logic                   dmi_resp_valid_o,
  input  logic                   dmi_resp_ready_i,
  output dm_reg_pkg::dmi_data_t  dmi_resp_data_o,
  // hart side
  input  dm_hart_pkg::hart_vec_t halted_i,
  input  dm_hart_pkg::hart_vec_t unavailable_i,
  input  dm_hart_pkg::hart_vec_t resumeack_i,
  output dm_hart_pkg::hart_vec_t haltreq_o,
  output dm_hart_pkg::hart_vec_t resumereq_o,
  output logic                   ndmreset_o,
  output logic                   dmactive_o,
  output logic                   clear_resumeack_o
);
  import dm_reg_pkg::*;
  import dm_hart_pkg::*;

  logic      fifo_full, fifo_empty, push, ack_havereset, sel_resumeack;
  logic      haltreq, resumereq;
  dmi_data_t push_data, dmstatus_word, haltsum0_word;
  hartsel_t  hartsel;
  hart_vec_t halted_ok, running, unavail, resumeack, havereset;

  dm_ctrl_regs u_ctrl_regs (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .req_valid_i (dmi_req_valid_i), .req_ready_o (dmi_req_ready_o),
    .req_op_i (dmi_req_op_i), .req_addr_i (dmi_req_addr_i), .req_data_i (dmi_req_data_i),
    .fifo_full_i (fifo_full), .push_o (push), .push_data_o (push_data),
    .dmstatus_i (dmstatus_word), .haltsum0_i (haltsum0_word),
    .sel_resumeack_i (sel_resumeack), .hartsel_o (hartsel),
    .haltreq_o (haltreq), .resumereq_o (resumereq), .ndmreset_o (ndmreset_o),
    .dmactive_o (dmactive_o), .ack_havereset_o (ack_havereset),
    .clear_resumeack_o (clear_resumeack_o)
  );

  // --------------------
  // one slice per hart
  for (genvar h = 0; h < `NR_HARTS; h++) begin : g_hart
    dm_hart_slice #(.HartIdx (h)) u_slice (
      .clk_i (clk_i), .rst_ni (rst_ni), .hartsel_i (hartsel),
      .haltreq_i (haltreq), .resumereq_i (resumereq), .ndmreset_i (ndmreset_o),
      .ack_havereset_i (ack_havereset), .halted_i (halted_i[h]),
      .unavailable_i (unavailable_i[h]), .resumeack_i (resumeack_i[h]),
      .haltreq_o (haltreq_o[h]), .resumereq_o (resumereq_o[h]),
      .halted_ok_o (halted_ok[h]), .running_o (running[h]), .unavail_o (unavail[h]),
      .resumeack_o (resumeack[h]), .havereset_o (havereset[h])
    );
  end

  dm_status_merge u_status_merge (
    .hartsel_i (hartsel), .halted_i (halted_i), .halted_ok_i (halted_ok),
    .running_i (running), .unavail_i (unavail), .resumeack_i (resumeack),
    .havereset_i (havereset), .dmstatus_o (dmstatus_word), .haltsum0_o (haltsum0_word),
    .sel_resumeack_o (sel_resumeack)
  );

  // response queue, popped whenever the debugger takes a word
  dm_resp_fifo u_resp_fifo (
    .clk_i (clk_i), .rst_ni (rst_ni), .push_i (push), .data_i (push_data),
    .pop_i (dmi_resp_ready_i & ~fifo_empty), .data_o (dmi_resp_data_o),
    .full_o (fifo_full), .empty_o (fifo_empty)
  );

  assign dmi_resp_valid_o = ~fifo_empty;

endmodule

// File: verilog/dm_status_merge.sv
/* status merger
   dmstatus for the selected hart and the haltsum0 word */

`include "dm_cfg.svh"

module dm_status_merge (
  input  dm_hart_pkg::hartsel_t  hartsel_i,
  input  dm_hart_pkg::hart_vec_t halted_i,
  input  dm_hart_pkg::hart_vec_t halted_ok_i,
  input  dm_hart_pkg::hart_vec_t running_i,
  input  dm_hart_pkg::hart_vec_t unavail_i,
  input  dm_hart_pkg::hart_vec_t resumeack_i,
  input  dm_hart_pkg::hart_vec_t havereset_i,
  output dm_reg_pkg::dmi_data_t  dmstatus_o,
  output dm_reg_pkg::dmi_data_t  haltsum0_o,
  output logic                   sel_resumeack_o
);
  import dm_reg_pkg::*;
  import dm_hart_pkg::*;

  logic hit;
  logic sel_halted, sel_running, sel_unavail, sel_resumeack, sel_havereset;

  // pick the selected hart, no hit means it does not exist
  always_comb begin
    hit           = 1'b0;
    sel_halted    = 1'b0;
    sel_running   = 1'b0;
    sel_unavail   = 1'b0;
    sel_resumeack = 1'b0;
    sel_havereset = 1'b0;
    for (int i = 0; i < `NR_HARTS; i++) begin
      if (hartsel_i == hartsel_t'(i)) begin
        hit           = 1'b1;
        sel_halted    = halted_ok_i[i];
        sel_running   = running_i[i];
        sel_unavail   = unavail_i[i];
        sel_resumeack = resumeack_i[i];
        sel_havereset = havereset_i[i];
      end
    end
  end

  // any and all carry the same value with a single selected hart
  always_comb begin
    dmstatus_o                     = '0;
    dmstatus_o[3:0]                = DM_VERSION;
    dmstatus_o[DMS_AUTHENTICATED]  = 1'b1;
    dmstatus_o[DMS_ANYHALTED]      = sel_halted;
    dmstatus_o[DMS_ALLHALTED]      = sel_halted;
    dmstatus_o[DMS_ANYRUNNING]     = sel_running;
    dmstatus_o[DMS_ALLRUNNING]     = sel_running;
    dmstatus_o[DMS_ANYUNAVAIL]     = sel_unavail;
    dmstatus_o[DMS_ALLUNAVAIL]     = sel_unavail;
    dmstatus_o[DMS_ANYNONEXISTENT] = ~hit;
    dmstatus_o[DMS_ALLNONEXISTENT] = ~hit;
    dmstatus_o[DMS_ANYRESUMEACK]   = sel_resumeack;
    dmstatus_o[DMS_ALLRESUMEACK]   = sel_resumeack;
    dmstatus_o[DMS_ANYHAVERESET]   = sel_havereset;
    dmstatus_o[DMS_ALLHAVERESET]   = sel_havereset;
  end

  // raw halted vector, not masked by unavailable
  always_comb begin
    haltsum0_o                 = '0;
    haltsum0_o[`NR_HARTS-1:0]  = halted_i;
  end

  assign sel_resumeack_o = sel_resumeack;

endmodule

// File: verilog/dm_hart_slice.sv
/* per-hart slice
   request routing by hart select, sticky havereset and status bits */

module dm_hart_slice #(
  parameter int unsigned HartIdx = 0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dm_hart_pkg::hartsel_t hartsel_i,
  input  logic                  haltreq_i,
  input  logic                  resumereq_i,
  input  logic                  ndmreset_i,
  input  logic                  ack_havereset_i,
  input  logic                  halted_i,
  input  logic                  unavailable_i,
  input  logic                  resumeack_i,
  output logic                  haltreq_o,
  output logic                  resumereq_o,
  output logic                  halted_ok_o,
  output logic                  running_o,
  output logic                  unavail_o,
  output logic                  resumeack_o,
  output logic                  havereset_o
);
  import dm_hart_pkg::*;

  logic selected;
  logic havereset_q;

  assign selected = (hartsel_i == hartsel_t'(HartIdx));

  // requests reach this hart only when it is selected
  assign haltreq_o   = selected & haltreq_i;
  assign resumereq_o = selected & resumereq_i;

  // halted and running never overlap with unavailable
  assign halted_ok_o = halted_i & ~unavailable_i;
  assign running_o   = ~halted_i & ~unavailable_i;
  assign unavail_o   = unavailable_i;
  assign resumeack_o = resumeack_i;

  // sticky havereset, ndmreset wins over the ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q <= 1'b1;
    end else if (ndmreset_i) begin
      havereset_q <= 1'b1;
    end else if (ack_havereset_i && selected) begin
      havereset_q <= 1'b0;
    end
  end

  assign havereset_o = havereset_q;

endmodule

// File: verilog/dm_ctrl_regs.sv
/* debug module control registers
   DMI request decode, dmcontrol with resume handshake, response select */

module dm_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  dm_reg_pkg::dtm_op_t   req_op_i,
  input  dm_reg_pkg::dmi_addr_t req_addr_i,
  input  dm_reg_pkg::dmi_data_t req_data_i,
  input  logic                  fifo_full_i,
  output logic                  push_o,
  output dm_reg_pkg::dmi_data_t push_data_o,
  input  dm_reg_pkg::dmi_data_t dmstatus_i,
  input  dm_reg_pkg::dmi_data_t haltsum0_i,
  input  logic                  sel_resumeack_i,
  output dm_hart_pkg::hartsel_t hartsel_o,
  output logic                  haltreq_o,
  output logic                  resumereq_o,
  output logic                  ndmreset_o,
  output logic                  dmactive_o,
  output logic                  ack_havereset_o,
  output logic                  clear_resumeack_o
);
  import dm_reg_pkg::*;
  import dm_hart_pkg::*;

  logic      accept;
  logic      dmc_write;
  dmi_data_t dmcontrol_word;

  logic      dmactive_q, dmactive_d;
  logic      ndmreset_q, ndmreset_d;
  logic      haltreq_q, haltreq_d;
  logic      resumereq_q, resumereq_d;
  hartsel_t  hartsel_q, hartsel_d;
  logic      clear_resumeack_q;

  // every accepted request pushes one response word
  assign req_ready_o = ~fifo_full_i;
  assign accept      = req_valid_i & req_ready_o;
  assign push_o      = accept;

  assign dmc_write = accept && (req_op_i == DTM_WRITE) && (req_addr_i == ADDR_DMCONTROL);

  // ackhavereset is a strobe and never stored
  assign ack_havereset_o = dmc_write & req_data_i[DMC_ACKHAVERESET];

  // --------------------
  // dmcontrol next state
  always_comb begin
    dmactive_d  = dmactive_q;
    ndmreset_d  = ndmreset_q;
    haltreq_d   = haltreq_q;
    resumereq_d = resumereq_q;
    hartsel_d   = hartsel_q;
    if (dmc_write) begin
      dmactive_d  = req_data_i[DMC_DMACTIVE];
      ndmreset_d  = req_data_i[DMC_NDMRESET];
      haltreq_d   = req_data_i[DMC_HALTREQ];
      resumereq_d = req_data_i[DMC_RESUMEREQ];
      hartsel_d   = req_data_i[DMC_HARTSEL_LSB +: $bits(hartsel_t)];
    end
    // hart acked the resume; skip the cycle where the old ack is being cleared
    if (resumereq_q && sel_resumeack_i && !clear_resumeack_q) begin
      resumereq_d = 1'b0;
    end
    // inactive module keeps everything but dmactive at zero
    if (!dmactive_d) begin
      ndmreset_d  = 1'b0;
      haltreq_d   = 1'b0;
      resumereq_d = 1'b0;
      hartsel_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q        <= 1'b0;
      ndmreset_q        <= 1'b0;
      haltreq_q         <= 1'b0;
      resumereq_q       <= 1'b0;
      hartsel_q         <= '0;
      clear_resumeack_q <= 1'b0;
    end else begin
      dmactive_q        <= dmactive_d;
      ndmreset_q        <= ndmreset_d;
      haltreq_q         <= haltreq_d;
      resumereq_q       <= resumereq_d;
      hartsel_q         <= hartsel_d;
      // high during the first cycle of resumereq only
      clear_resumeack_q <= ~resumereq_q & resumereq_d;
    end
  end

  // --------------------
  // read data
  always_comb begin
    dmcontrol_word                                         = '0;
    dmcontrol_word[DMC_HALTREQ]                            = haltreq_q;
    dmcontrol_word[DMC_RESUMEREQ]                          = resumereq_q;
    dmcontrol_word[DMC_HARTSEL_LSB +: $bits(hartsel_t)]    = hartsel_q;
    dmcontrol_word[DMC_NDMRESET]                           = ndmreset_q;
    dmcontrol_word[DMC_DMACTIVE]                           = dmactive_q;
  end

  // writes and nops answer zero, so do unmapped reads
  always_comb begin
    push_data_o = '0;
    case (req_op_i)
      DTM_READ: begin
        case (req_addr_i)
          ADDR_DMCONTROL: push_data_o = dmcontrol_word;
          ADDR_DMSTATUS:  push_data_o = dmstatus_i;
          ADDR_HALTSUM0:  push_data_o = haltsum0_i;
          default:        push_data_o = '0;
        endcase
      end
      default: push_data_o = '0;
    endcase
  end

  assign hartsel_o         = hartsel_q;
  assign haltreq_o         = haltreq_q;
  assign resumereq_o       = resumereq_q;
  assign ndmreset_o        = ndmreset_q;
  assign dmactive_o        = dmactive_q;
  assign clear_resumeack_o = clear_resumeack_q;

endmodule

// File: verilog/dm_resp_fifo.sv
/* DMI response queue
   circular buffer of response words, kept in request order */

`include "dm_cfg.svh"

module dm_resp_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  dm_reg_pkg::dmi_data_t data_i,
  input  logic                  pop_i,
  output dm_reg_pkg::dmi_data_t data_o,
  output logic                  full_o,
  output logic                  empty_o
);
  import dm_reg_pkg::*;

  localparam int unsigned Depth = `RESP_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  dmi_data_t         mem_q [Depth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   count_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers and fill level, wrapping at Depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: verilog/dm_hart_pkg.sv
/* hart-side types
   hart select value and one-bit-per-hart vector */

`include "dm_cfg.svh"

package dm_hart_pkg;

  // selected hart index as written to dmcontrol
  typedef logic [`HARTSEL_W-1:0] hartsel_t;

  // one bit per hart
  typedef logic [`NR_HARTS-1:0] hart_vec_t;

endpackage

// File: verilog/dm_reg_pkg.sv
/* debug module register map
   DMI types, op codes, register addresses and field positions */

`include "dm_cfg.svh"

package dm_reg_pkg;

  typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
  typedef logic [`DMI_DATA_W-1:0] dmi_data_t;
  typedef logic [1:0]             dtm_op_t;

  // DMI op codes
  localparam dtm_op_t DTM_NOP   = 2'd0;
  localparam dtm_op_t DTM_READ  = 2'd1;
  localparam dtm_op_t DTM_WRITE = 2'd2;

  // --------------------
  // register addresses
  localparam dmi_addr_t ADDR_DMCONTROL = 7'h10;
  localparam dmi_addr_t ADDR_DMSTATUS  = 7'h11;
  localparam dmi_addr_t ADDR_HALTSUM0  = 7'h40;

  // --------------------
  // dmcontrol fields
  localparam int unsigned DMC_HALTREQ      = 31;
  localparam int unsigned DMC_RESUMEREQ    = 30;
  localparam int unsigned DMC_ACKHAVERESET = 28;
  localparam int unsigned DMC_HARTSEL_LSB  = 16;
  localparam int unsigned DMC_NDMRESET     = 1;
  localparam int unsigned DMC_DMACTIVE     = 0;

  // --------------------
  // dmstatus fields
  localparam int unsigned DMS_AUTHENTICATED  = 7;
  localparam int unsigned DMS_ANYHALTED      = 8;
  localparam int unsigned DMS_ALLHALTED      = 9;
  localparam int unsigned DMS_ANYRUNNING     = 10;
  localparam int unsigned DMS_ALLRUNNING     = 11;
  localparam int unsigned DMS_ANYUNAVAIL     = 12;
  localparam int unsigned DMS_ALLUNAVAIL     = 13;
  localparam int unsigned DMS_ANYNONEXISTENT = 14;
  localparam int unsigned DMS_ALLNONEXISTENT = 15;
  localparam int unsigned DMS_ANYRESUMEACK   = 16;
  localparam int unsigned DMS_ALLRESUMEACK   = 17;
  localparam int unsigned DMS_ANYHAVERESET   = 18;
  localparam int unsigned DMS_ALLHAVERESET   = 19;

  // debug spec 0.13, dmstatus bits 3:0
  localparam logic [3:0] DM_VERSION = 4'd2;

endpackage

// File: verilog/dm_cfg.svh
/* debug module configuration
   hart count, DMI widths and response queue depth */

`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// number of harts behind the debug module, 1 to 32
`define NR_HARTS 4

// hartsello field, hartselhi is not kept
`define HARTSEL_W 10

// DMI request and response widths
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

`define RESP_DEPTH 2

`endif
